//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module tb_frame_filter \
		--Mdir obj_dir -o sim_frame_filter
	./obj_dir/sim_frame_filter | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module tb_frame_filter

clean:
	rm -rf obj_dir sim.log

//--- build.f
frame_pkg.sv
frame_len_check.sv
frame_fifo.sv
frame_regs.sv
frame_filter_top.sv
tb_clk_gen.sv
tb_frame_checker.sv
frame_fifo_assert.sv
tb_frame_filter.sv

//--- frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo
  import frame_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] chk_data,
  input  logic                  chk_valid,
  input  logic                  chk_last,
  input  logic                  chk_bad,
  input  logic                  drop_when_full,
  input  logic                  out_ready,
  output logic                  in_ready,
  output logic [data_width-1:0] out_data,
  output logic                  out_valid,
  output logic                  out_last,
  output logic                  ev_ok,
  output logic                  ev_bad,
  output logic                  ev_ovf
);

  logic [fifo_addr_width:0] wr_ptr;     // End of committed frames.
  logic [fifo_addr_width:0] wr_cur;     // Cursor of the frame being written.
  logic [fifo_addr_width:0] rd_ptr;
  logic [fifo_addr_width:0] wr_ptr_rd;  // Committed end seen by the read side.

  logic [data_width:0] mem [fifo_depth];

  logic drop;
  logic xfer;
  logic mem_full;
  logic stored_empty;
  logic swallow;
  logic wr_en;
  logic rd_empty;
  logic rd_en;

  assign xfer = chk_valid && in_ready;

  // Cursor has lapped the read pointer.
  assign mem_full = (wr_cur[fifo_addr_width] != rd_ptr[fifo_addr_width]) &&
                    (wr_cur[fifo_addr_width-1:0] == rd_ptr[fifo_addr_width-1:0]);

  assign stored_empty = wr_ptr == rd_ptr;

  // Full with nothing committed means the frame can never fit, so keep taking
  // beats and drop it instead of stalling forever.
  assign in_ready = drop_when_full || drop || !mem_full || stored_empty;

  assign swallow = drop || mem_full;
  assign wr_en   = xfer && !swallow;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_cur[fifo_addr_width-1:0]] <= {chk_last, chk_data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      wr_cur <= '0;
      drop   <= 1'b0;
      ev_ok  <= 1'b0;
      ev_bad <= 1'b0;
      ev_ovf <= 1'b0;
    end else begin
      ev_ok  <= 1'b0;
      ev_bad <= 1'b0;
      ev_ovf <= 1'b0;
      if (xfer) begin
        if (swallow) begin
          drop <= !chk_last;
          if (chk_last) begin
            wr_cur <= wr_ptr;  // Rewind over the partial frame.
            ev_ovf <= 1'b1;
          end
        end else if (chk_last && chk_bad) begin
          wr_cur <= wr_ptr;
          ev_bad <= 1'b1;
        end else begin
          wr_cur <= wr_cur + 1'b1;
          if (chk_last) begin
            wr_ptr <= wr_cur + 1'b1;  // Commit.
            ev_ok  <= 1'b1;
          end
        end
      end
    end
  end

  assign rd_empty = wr_ptr_rd == rd_ptr;
  assign rd_en    = (out_ready || !out_valid) && !rd_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_rd <= '0;
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      wr_ptr_rd <= wr_ptr;
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (out_ready || !out_valid) begin
        out_valid <= !rd_empty;
      end
    end
  end

  // Output register refills in the same cycle a beat leaves.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      {out_last, out_data} <= mem[rd_ptr[fifo_addr_width-1:0]];
    end
  end

endmodule

//--- frame_fifo_assert.sv
`timescale 1ns/1ps

module frame_fifo_assert (
  input logic       clk,
  input logic       rst,
  input logic [7:0] out_data,
  input logic       out_valid,
  input logic       out_ready,
  input logic       out_last,
  input logic       ev_ok,
  input logic       ev_bad,
  input logic       ev_ovf
);

  a_valid_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after reset");

  a_one_event: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ev_ok, ev_bad, ev_ovf}))
    else $error("more than one event pulse");

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else $error("output changed while stalled");

endmodule

bind frame_fifo frame_fifo_assert u_fifo_assert (.*);

//--- frame_filter_top.sv
`timescale 1ns/1ps

module frame_filter_top
  import frame_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [data_width-1:0]    in_data,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic                     in_last,
  input  logic                     in_user,
  output logic [data_width-1:0]    out_data,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic                     out_last,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [wb_adr_width-1:0]  wb_adr,
  input  logic [wb_data_width-1:0] wb_wdata,
  output logic [wb_data_width-1:0] wb_rdata,
  output logic                     wb_ack
);

  logic [data_width-1:0] chk_data;
  logic                  chk_valid;
  logic                  chk_last;
  logic                  chk_bad;
  logic                  enable;
  logic                  drop_when_full;
  logic [len_width-1:0]  max_len;
  logic [len_width-1:0]  min_len;
  logic                  ev_ok;
  logic                  ev_bad;
  logic                  ev_ovf;

  frame_len_check u_len_check (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_last   (in_last),
    .in_user   (in_user),
    .enable    (enable),
    .max_len   (max_len),
    .min_len   (min_len),
    .chk_data  (chk_data),
    .chk_valid (chk_valid),
    .chk_last  (chk_last),
    .chk_bad   (chk_bad)
  );

  frame_fifo u_fifo (
    .clk            (clk),
    .rst            (rst),
    .chk_data       (chk_data),
    .chk_valid      (chk_valid),
    .chk_last       (chk_last),
    .chk_bad        (chk_bad),
    .drop_when_full (drop_when_full),
    .out_ready      (out_ready),
    .in_ready       (in_ready),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_last       (out_last),
    .ev_ok          (ev_ok),
    .ev_bad         (ev_bad),
    .ev_ovf         (ev_ovf)
  );

  frame_regs u_regs (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_wdata       (wb_wdata),
    .ev_ok          (ev_ok),
    .ev_bad         (ev_bad),
    .ev_ovf         (ev_ovf),
    .wb_rdata       (wb_rdata),
    .wb_ack         (wb_ack),
    .enable         (enable),
    .drop_when_full (drop_when_full),
    .max_len        (max_len),
    .min_len        (min_len)
  );

endmodule

//--- frame_len_check.sv
`timescale 1ns/1ps

module frame_len_check
  import frame_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] in_data,
  input  logic                  in_valid,
  input  logic                  in_ready,
  input  logic                  in_last,
  input  logic                  in_user,
  input  logic                  enable,
  input  logic [len_width-1:0]  max_len,
  input  logic [len_width-1:0]  min_len,
  output logic [data_width-1:0] chk_data,
  output logic                  chk_valid,
  output logic                  chk_last,
  output logic                  chk_bad
);

  logic                 xfer;
  logic [len_width-1:0] beat_cnt;  // Beats already taken in this frame.
  logic [len_width-1:0] cur_len;
  logic                 in_frame;
  logic                 en_held;
  logic                 user_held;
  logic                 frame_en;
  logic                 frame_user;

  assign xfer     = in_valid && in_ready;
  assign in_frame = beat_cnt != '0;

  // Length including the current beat, saturating.
  assign cur_len = (&beat_cnt) ? beat_cnt : beat_cnt + 1'b1;

  assign frame_en   = in_frame ? en_held : enable;  // Sampled on the first beat.
  assign frame_user = user_held || in_user;

  assign chk_data  = in_data;
  assign chk_valid = in_valid;
  assign chk_last  = in_last;

  assign chk_bad = in_last && ((cur_len < min_len) || (cur_len > max_len) ||
                               frame_user || !frame_en);

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt  <= '0;
      en_held   <= 1'b0;
      user_held <= 1'b0;
    end else if (xfer) begin
      if (in_last) begin
        beat_cnt  <= '0;
        user_held <= 1'b0;
      end else begin
        beat_cnt  <= cur_len;
        en_held   <= frame_en;
        user_held <= frame_user;  // Error flag sticks for the frame.
      end
    end
  end

endmodule

//--- frame_pkg.sv
package frame_pkg;

  // Stream and memory geometry.
  localparam int data_width      = 8;
  localparam int fifo_addr_width = 6;
  localparam int fifo_depth      = 2 ** fifo_addr_width;

  localparam int len_width     = 16;
  localparam int cnt_width     = 16;
  localparam int wb_adr_width  = 3;
  localparam int wb_data_width = 16;

  // Word addresses of the register block.
  localparam logic [wb_adr_width-1:0] reg_ctrl    = 3'd0;
  localparam logic [wb_adr_width-1:0] reg_max_len = 3'd1;
  localparam logic [wb_adr_width-1:0] reg_min_len = 3'd2;
  localparam logic [wb_adr_width-1:0] reg_cnt_ok  = 3'd3;
  localparam logic [wb_adr_width-1:0] reg_cnt_bad = 3'd4;
  localparam logic [wb_adr_width-1:0] reg_cnt_ovf = 3'd5;

  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_drop_bit   = 1;

  localparam logic [len_width-1:0] def_max_len = 16'd1518; // Ethernet maximum.
  localparam logic [len_width-1:0] def_min_len = 16'd1;

endpackage

//--- frame_regs.sv
`timescale 1ns/1ps

module frame_regs
  import frame_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [wb_adr_width-1:0]  wb_adr,
  input  logic [wb_data_width-1:0] wb_wdata,
  input  logic                     ev_ok,
  input  logic                     ev_bad,
  input  logic                     ev_ovf,
  output logic [wb_data_width-1:0] wb_rdata,
  output logic                     wb_ack,
  output logic                     enable,
  output logic                     drop_when_full,
  output logic [len_width-1:0]     max_len,
  output logic [len_width-1:0]     min_len
);

  logic                     req;
  logic                     wr;
  logic [cnt_width-1:0]     cnt_ok;
  logic [cnt_width-1:0]     cnt_bad;
  logic [cnt_width-1:0]     cnt_ovf;
  logic [wb_data_width-1:0] ctrl_word;

  function automatic logic [cnt_width-1:0] cnt_step(
    input logic [cnt_width-1:0] cnt,
    input logic                 ev,
    input logic                 clr
  );
    logic [cnt_width-1:0] nxt;
    nxt = cnt;
    if (clr) begin
      nxt = '0;
    end else if (ev && !(&cnt)) begin
      nxt = cnt + 1'b1;  // Saturates at all ones.
    end
    return nxt;
  endfunction

  assign req = wb_cyc && wb_stb && !wb_ack;
  assign wr  = req && wb_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;  // Single-cycle ack, then at least one low.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enable         <= 1'b0;
      drop_when_full <= 1'b0;
      max_len        <= def_max_len;
      min_len        <= def_min_len;
    end else if (wr) begin
      case (wb_adr)
        reg_ctrl: begin
          enable         <= wb_wdata[ctrl_enable_bit];
          drop_when_full <= wb_wdata[ctrl_drop_bit];
        end
        reg_max_len: max_len <= wb_wdata[len_width-1:0];
        reg_min_len: min_len <= wb_wdata[len_width-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_ok  <= '0;
      cnt_bad <= '0;
      cnt_ovf <= '0;
    end else begin
      cnt_ok  <= cnt_step(cnt_ok, ev_ok, wr && (wb_adr == reg_cnt_ok));
      cnt_bad <= cnt_step(cnt_bad, ev_bad, wr && (wb_adr == reg_cnt_bad));
      cnt_ovf <= cnt_step(cnt_ovf, ev_ovf, wr && (wb_adr == reg_cnt_ovf));
    end
  end

  always_comb begin
    ctrl_word                  = '0;
    ctrl_word[ctrl_enable_bit] = enable;
    ctrl_word[ctrl_drop_bit]   = drop_when_full;
  end

  // Read mux shows the live register value during the ack cycle.
  always_comb begin
    case (wb_adr)
      reg_ctrl:    wb_rdata = ctrl_word;
      reg_max_len: wb_rdata = wb_data_width'(max_len);
      reg_min_len: wb_rdata = wb_data_width'(min_len);
      reg_cnt_ok:  wb_rdata = wb_data_width'(cnt_ok);
      reg_cnt_bad: wb_rdata = wb_data_width'(cnt_bad);
      reg_cnt_ovf: wb_rdata = wb_data_width'(cnt_ovf);
      default:     wb_rdata = '0;
    endcase
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- tb_frame_checker.sv
`timescale 1ns/1ps

module tb_frame_checker (
  input logic       clk,
  input logic       rst,
  input logic [7:0] out_data,
  input logic       out_valid,
  input logic       out_ready,
  input logic       out_last,
  input logic       in_ready,
  input logic       wb_ack
);

  logic [7:0] exp_data [$];
  int         exp_len [$];
  logic [7:0] got [$];
  int         errors = 0;
  int         delivered = 0;
  int         ack_count = 0;
  logic       subseq = 1'b0;       // Dropped frames may be skipped.
  logic       ready_watch = 1'b0;

  function automatic void check_eq(input string name, input int got_v, input int exp_v);
    if (got_v != exp_v) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got_v, exp_v);
      errors++;
    end
  endfunction

  function automatic void report(input string msg);
    $display("Error: %s", msg);
    errors++;
  endfunction

  function automatic void push_byte(input logic [7:0] b);
    exp_data.push_back(b);
  endfunction

  function automatic void push_len(input int n);
    exp_len.push_back(n);
  endfunction

  function automatic void flush();
    exp_data.delete();
    exp_len.delete();
  endfunction

  function automatic int pending();
    return exp_len.size();
  endfunction

  // Compare the collected frame with the head of the model queue.
  function automatic void match_frame();
    int         n;
    logic       hit;
    logic [7:0] b;
    hit = 1'b0;
    while (!hit && exp_len.size() > 0) begin
      n   = exp_len.pop_front();
      hit = n == got.size();
      for (int i = 0; i < n; i++) begin
        b = exp_data.pop_front();
        if (i < got.size() && b != got[i]) begin
          hit = 1'b0;
          if (!subseq) check_eq("out_data", got[i], b);
        end
      end
      if (!subseq) begin
        check_eq("frame length", got.size(), n);
        hit = 1'b1;
      end
    end
    if (!hit) report("output frame matches no expected frame");
  endfunction

  always @(posedge clk) begin
    if (!rst) begin
      if (wb_ack) ack_count++;
      if (ready_watch && !in_ready) begin
        report("in_ready fell while drop_when_full was set");
        ready_watch = 1'b0;
      end
      if (out_valid && out_ready) begin
        got.push_back(out_data);
        if (out_last) begin
          match_frame();
          got.delete();
          delivered++;
        end
      end
    end
  end

endmodule

//--- tb_frame_filter.sv
`timescale 1ns/1ps

module tb_frame_filter
  import frame_pkg::*;
();

  // Upper bound on beats over all tests.
  localparam int beat_budget = 40 * 64 + 35 * 64 + 40 * 64 + 2 * 70 + 4 * 70;

  logic                     clk;
  logic                     rst;
  logic [data_width-1:0]    in_data;
  logic                     in_valid;
  logic                     in_ready;
  logic                     in_last;
  logic                     in_user;
  logic [data_width-1:0]    out_data;
  logic                     out_valid;
  logic                     out_ready;
  logic                     out_last;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [wb_adr_width-1:0]  wb_adr;
  logic [wb_data_width-1:0] wb_wdata;
  logic [wb_data_width-1:0] wb_rdata;
  logic                     wb_ack;

  logic [31:0] lfsr_state = 32'h3d66;
  logic [31:0] rdy_state = 32'h3d66;
  int          ready_mode = 0;  // 0 always, 1 random, 2 long stretches.
  logic        gaps_on = 1'b0;
  logic        en_s = 1'b0;
  int          min_s = 1;
  int          max_s = 1518;
  int          test_num = 0;
  int          passed = 0;
  int          err0 = 0;

  tb_clk_gen u_clk (.clk(clk), .rst(rst));

  frame_filter_top uut (.*);

  tb_frame_checker u_chk (
    .clk(clk), .rst(rst), .out_data(out_data), .out_valid(out_valid),
    .out_ready(out_ready), .out_last(out_last), .in_ready(in_ready), .wb_ack(wb_ack)
  );

  // Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic lfsr_bit(inout logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    s  = {s[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit(lfsr_state));
    return v;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + rand_bits(8) % (hi - lo + 1);
  endfunction

  function automatic logic frame_good(input int len, input logic user);
    return en_s && !user && len >= min_s && len <= max_s;
  endfunction

  task automatic wb_access(input logic we, input logic [wb_adr_width-1:0] adr,
                           input logic [wb_data_width-1:0] wdata,
                           output logic [wb_data_width-1:0] rdata);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 20);
    if (!wb_ack) u_chk.report("Wishbone access got no ack");
    rdata = wb_rdata;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [wb_adr_width-1:0] adr, input int data);
    logic [wb_data_width-1:0] dummy;
    wb_access(1'b1, adr, wb_data_width'(data), dummy);
  endtask

  task automatic check_reg(input logic [wb_adr_width-1:0] adr, input string name,
                           input int exp_v);
    logic [wb_data_width-1:0] v;
    wb_access(1'b0, adr, '0, v);
    u_chk.check_eq(name, int'(v), exp_v);
  endtask

  task automatic configure(input logic en, input logic drop, input int mn, input int mx);
    en_s  = en;
    min_s = mn;
    max_s = mx;
    wb_write(reg_ctrl, (int'(drop) << ctrl_drop_bit) | (int'(en) << ctrl_enable_bit));
    wb_write(reg_min_len, mn);
    wb_write(reg_max_len, mx);
  endtask

  task automatic send_frame(input int len, input logic user_err, input logic push);
    int         upos;
    int         gap;
    logic       took;
    logic [7:0] b;
    upos = user_err ? rand_bits(8) % len : -1;
    for (int i = 0; i < len; i++) begin
      b = 8'(rand_bits(8));
      if (push) u_chk.push_byte(b);
      gap      = gaps_on ? rand_bits(2) : 0;
      in_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      in_valid = 1'b1;
      in_data  = b;
      in_last  = i == len - 1;
      in_user  = i == upos;
      do begin
        @(negedge clk);
        took = in_ready;
        @(posedge clk);
        #1;
      end while (!took);
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_user  = 1'b0;
    if (push) u_chk.push_len(len);
  endtask

  // Wait until every frame has raised an event and all good ones left.
  task automatic settle(input int n, output int ok, output int bad, output int ovf);
    logic [wb_data_width-1:0] v;
    ready_mode = 0;
    do begin
      wb_access(1'b0, reg_cnt_ok, '0, v);
      ok = int'(v);
      wb_access(1'b0, reg_cnt_bad, '0, v);
      bad = int'(v);
      wb_access(1'b0, reg_cnt_ovf, '0, v);
      ovf = int'(v);
    end while (ok + bad + ovf < n);
    wait (u_chk.delivered >= ok);
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test();
    test_num++;
    wb_write(reg_cnt_ok, 0);
    wb_write(reg_cnt_bad, 0);
    wb_write(reg_cnt_ovf, 0);
    u_chk.delivered = 0;
    err0 = u_chk.errors;
  endtask

  task automatic end_test(input string name);
    if (u_chk.errors == err0) passed++;
    $display("Test %0d %s: %s", test_num, name, (u_chk.errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    forever begin
      @(posedge clk);
      #1;
      case (ready_mode)
        0: out_ready = 1'b1;
        1: out_ready = lfsr_bit(rdy_state);
        default: begin
          if (lfsr_bit(rdy_state) && lfsr_bit(rdy_state) && lfsr_bit(rdy_state)) begin
            out_ready = ~out_ready;
            repeat (out_ready ? 20 : 150) @(posedge clk);
          end
        end
      endcase
    end
  end

  initial begin
    repeat (beat_budget * 20 + 2000) @(posedge clk);
    $display("Error: run timed out waiting for the DUT");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int acks;
    int ok;
    int bad;
    int ovf;
    int n_good;
    int n_bad;
    int kind;
    int len;
    in_data   = '0;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    in_user   = 1'b0;
    out_ready = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdata  = '0;
    @(negedge rst);
    @(posedge clk);
    #1;

    // Register access.
    test_num++;
    err0 = u_chk.errors;
    acks = u_chk.ack_count;
    check_reg(reg_ctrl, "ctrl", 0);
    check_reg(reg_max_len, "max_len", 1518);
    check_reg(reg_min_len, "min_len", 1);
    check_reg(reg_cnt_ok, "cnt_ok", 0);
    check_reg(reg_cnt_bad, "cnt_bad", 0);
    check_reg(reg_cnt_ovf, "cnt_ovf", 0);
    configure(1'b1, 1'b1, 4, 100);
    check_reg(reg_ctrl, "ctrl", 3);
    check_reg(reg_max_len, "max_len", 100);
    check_reg(reg_min_len, "min_len", 4);
    u_chk.check_eq("wb_ack count", u_chk.ack_count - acks, 12);
    end_test("register access");

    // Good frames under back-pressure.
    begin_test();
    configure(1'b1, 1'b0, 1, 100);
    ready_mode = 1;
    gaps_on    = 1'b1;
    for (int f = 0; f < 40; f++) send_frame(rand_range(1, 64), 1'b0, 1'b1);
    settle(40, ok, bad, ovf);
    u_chk.check_eq("cnt_ok", ok, 40);
    u_chk.check_eq("cnt_bad", bad, 0);
    u_chk.check_eq("cnt_ovf", ovf, 0);
    u_chk.check_eq("pending frames", u_chk.pending(), 0);
    end_test("good frames");

    // Runt, oversize, error-flagged and disabled frames.
    begin_test();
    configure(1'b1, 1'b0, 4, 40);
    ready_mode = 1;
    n_good     = 0;
    n_bad      = 0;
    for (int f = 0; f < 35; f++) begin
      if (f == 30) configure(1'b0, 1'b0, 4, 40);
      kind = rand_bits(2);
      len  = (kind == 0) ? rand_range(1, 3) : (kind == 1) ? rand_range(41, 64) :
             rand_range(4, 40);
      if (frame_good(len, kind == 2)) n_good++;
      else n_bad++;
      send_frame(len, kind == 2, frame_good(len, kind == 2));
    end
    settle(35, ok, bad, ovf);
    u_chk.check_eq("cnt_ok", ok, n_good);
    u_chk.check_eq("cnt_bad", bad, n_bad);
    u_chk.check_eq("cnt_ovf", ovf, 0);
    u_chk.check_eq("pending frames", u_chk.pending(), 0);
    end_test("bad frames");

    // Drop when full.
    begin_test();
    configure(1'b1, 1'b1, 1, 100);
    gaps_on           = 1'b0;
    u_chk.subseq      = 1'b1;
    u_chk.ready_watch = 1'b1;
    ready_mode        = 2;
    for (int f = 0; f < 40; f++) send_frame(rand_range(1, 64), 1'b0, 1'b1);
    settle(40, ok, bad, ovf);
    u_chk.ready_watch = 1'b0;
    u_chk.subseq      = 1'b0;
    u_chk.flush();
    u_chk.check_eq("cnt_ok plus cnt_ovf", ok + ovf, 40);
    u_chk.check_eq("cnt_bad", bad, 0);
    end_test("overflow drop");

    // A frame larger than the memory, in both policies.
    begin_test();
    for (int p = 0; p < 2; p++) begin
      configure(1'b1, p[0], 1, 200);
      send_frame(70, 1'b0, 1'b0);
      settle(p + 1, ok, bad, ovf);
      u_chk.check_eq("cnt_ovf", ovf, p + 1);
      u_chk.check_eq("cnt_ok", ok, 0);
    end
    end_test("oversize for memory");

    // Counter clear.
    begin_test();
    configure(1'b1, 1'b0, 1, 200);
    send_frame(10, 1'b0, 1'b1);
    send_frame(10, 1'b1, 1'b0);
    send_frame(70, 1'b0, 1'b0);
    settle(3, ok, bad, ovf);
    u_chk.check_eq("cnt_ok", ok, 1);
    u_chk.check_eq("cnt_bad", bad, 1);
    u_chk.check_eq("cnt_ovf", ovf, 1);
    wb_write(reg_cnt_ok, 0);
    wb_write(reg_cnt_bad, 0);
    wb_write(reg_cnt_ovf, 0);
    check_reg(reg_cnt_ok, "cnt_ok", 0);
    check_reg(reg_cnt_bad, "cnt_bad", 0);
    check_reg(reg_cnt_ovf, "cnt_ovf", 0);
    u_chk.delivered = 0;
    send_frame(12, 1'b0, 1'b1);
    settle(1, ok, bad, ovf);
    u_chk.check_eq("cnt_ok", ok, 1);
    u_chk.check_eq("cnt_bad", bad, 0);
    u_chk.check_eq("cnt_ovf", ovf, 0);
    send_frame(12, 1'b1, 1'b0);
    settle(2, ok, bad, ovf);
    u_chk.check_eq("cnt_ok", ok, 1);
    u_chk.check_eq("cnt_bad", bad, 1);
    u_chk.check_eq("cnt_ovf", ovf, 0);
    send_frame(70, 1'b0, 1'b0);
    settle(3, ok, bad, ovf);
    u_chk.check_eq("cnt_ovf", ovf, 1);
    u_chk.check_eq("cnt_ok", ok, 1);
    u_chk.check_eq("cnt_bad", bad, 1);
    end_test("counter clear");

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             test_num, passed, test_num - passed, u_chk.errors);
    if (u_chk.errors == 0 && passed == test_num) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
